/* include/mdc_defines.svh */
// determinant calculator widths
`ifndef MDC_DEFINES_SVH
`define MDC_DEFINES_SVH

// ======================================================================
// input code words
// ======================================================================

// 11 data bits plus 4 parity bits
`define MDC_CODE_W        15
`define MDC_ELEM_W        11
// 5 mode bits plus 4 parity bits
`define MDC_MODE_CODE_W   9
`define MDC_MODE_W        5

// ======================================================================
// matrix and results
// ======================================================================

`define MDC_DIM           4
`define MDC_NUM_ELEM      16
// 2x2 minor of two 11-bit products
`define MDC_DET2_W        23
// 3x3 slot as laid out in the output word
`define MDC_DET3_W        51
`define MDC_NUM_DET2      9
`define MDC_NUM_DET3      4
`define MDC_OUT_W         207
// sum of three 34-bit cofactor terms
`define MDC_ACC_W         36
// corrected mode bit that picks 3x3 mode
`define MDC_MODE_DET3_BIT 1

`endif

/* source/mdc_pkg.sv */
// determinant calculator types
`include "mdc_defines.svh"

package mdc_pkg;

    // ==================================================================
    // element and result types
    // ==================================================================

    typedef logic signed [`MDC_ELEM_W-1:0] elem_t;
    typedef logic signed [`MDC_DET2_W-1:0] det2_t;
    typedef logic signed [`MDC_DET3_W-1:0] det3_t;

    // one corrected word from the input decoder
    typedef struct packed {
        logic                   strobe;
        logic                   first;
        elem_t                  value;
        logic [`MDC_MODE_W-1:0] mode;
    } dec_word_t;

    // row-major, element 0 is row 0 column 0
    typedef struct packed {
        elem_t [`MDC_NUM_ELEM-1:0] elems;
        logic [`MDC_MODE_W-1:0]    mode;
    } matrix_t;

    // unused top bits above the four 3x3 slots
    localparam int DET3_PAD_W = `MDC_OUT_W - `MDC_NUM_DET3 * `MDC_DET3_W;

    typedef struct packed {
        logic [DET3_PAD_W-1:0]       pad;
        det3_t [`MDC_NUM_DET3-1:0]   slot;
    } det3_view_t;

    // same output word, read as nine 2x2 or four 3x3 results
    typedef union packed {
        det2_t [`MDC_NUM_DET2-1:0] det2_view;
        det3_view_t                det3_view;
    } out_word_t;

    // ==================================================================
    // hamming single error correction
    // ==================================================================

    // position 1 is the code msb, parity at 1 2 4 8
    // shorter codes are passed left aligned with zero fill
    function automatic logic [`MDC_ELEM_W-1:0] ham_correct(
        input logic [`MDC_CODE_W-1:0] code
    );
        logic [3:0]             syn;
        logic [`MDC_CODE_W-1:0] fixed;
        logic [`MDC_ELEM_W-1:0] data;
        int                     k;
        // syndrome is the xor of all set positions
        syn = '0;
        for (int p = 1; p <= `MDC_CODE_W; p++) begin
            if (code[`MDC_CODE_W - p]) begin
                syn = syn ^ 4'(p);
            end
        end
        // nonzero syndrome names the flipped position
        fixed = code;
        if (syn != 4'd0) begin
            fixed[`MDC_CODE_W - syn] = ~fixed[`MDC_CODE_W - syn];
        end
        // gather data positions, msb first
        data = '0;
        k    = `MDC_ELEM_W;
        for (int p = 1; p <= `MDC_CODE_W; p++) begin
            if ((p & (p - 1)) != 0) begin
                k       = k - 1;
                data[k] = fixed[`MDC_CODE_W - p];
            end
        end
        return data;
    endfunction

endpackage

/* source/mdc_input_decoder.sv */
// input code word decoder
`timescale 1ns/1ps
`include "mdc_defines.svh"

module mdc_input_decoder (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  logic [`MDC_CODE_W-1:0]      in_data,
    input  logic [`MDC_MODE_CODE_W-1:0] in_mode,
    output mdc_pkg::dec_word_t          word
);
    import mdc_pkg::*;

    // ==================================================================
    // declarations
    // ==================================================================

    // high while a matrix is streaming in, one cycle behind in_valid
    logic                   in_run;
    logic                   first_q;
    // corrected code words
    logic [`MDC_ELEM_W-1:0] data_fix;
    logic [`MDC_ELEM_W-1:0] mode_fix;
    // registered payload
    elem_t                  value_q;
    logic [`MDC_MODE_W-1:0] mode_q;

    // ==================================================================
    // correction
    // ==================================================================

    assign data_fix = ham_correct(in_data);

    // mode code sits in the top of a data sized code word
    // zero fill cannot move the syndrome
    assign mode_fix = ham_correct(
        {in_mode, {(`MDC_CODE_W - `MDC_MODE_CODE_W){1'b0}}}
    );

    // ==================================================================
    // registers
    // ==================================================================

    // run flag follows in_valid
    // a valid cycle with the flag low is the first word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_run  <= 1'b0;
            first_q <= 1'b0;
        end else begin
            in_run  <= in_valid;
            first_q <= in_valid && !in_run;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            value_q <= data_fix;
            // mode only arrives with the first element
            if (!in_run) begin
                mode_q <= mode_fix[`MDC_ELEM_W-1 -: `MDC_MODE_W];
            end
        end
    end

    // strobe is the run flag itself
    assign word = '{
        strobe: in_run,
        first:  first_q,
        value:  value_q,
        mode:   mode_q
    };

endmodule

/* source/mdc_matrix_buffer.sv */
// matrix store
`timescale 1ns/1ps
`include "mdc_defines.svh"

module mdc_matrix_buffer (
    input  logic               clk,
    input  logic               rst_n,
    input  mdc_pkg::dec_word_t word,
    output mdc_pkg::matrix_t   matrix,
    output logic               start
);
    import mdc_pkg::*;

    // ==================================================================
    // declarations
    // ==================================================================

    // element store, shifts down so the first word ends at index 0
    elem_t [`MDC_NUM_ELEM-1:0] elems_q;
    logic [`MDC_MODE_W-1:0]    mode_q;
    // elements already landed in this matrix
    logic [3:0]                fill_q;
    logic [3:0]                fill_base;
    logic                      last_elem;

    // a first word restarts the count
    assign fill_base = word.first ? 4'd0 : fill_q;
    // sixteenth element on this strobe
    assign last_elem = word.strobe && (fill_base == 4'(`MDC_NUM_ELEM - 1));

    // ==================================================================
    // fill count and start
    // ==================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_q <= 4'd0;
            start  <= 1'b0;
        end else begin
            // pulse lines up with the last element landing
            start <= last_elem;
            if (word.strobe) begin
                // wraps to zero after sixteen
                fill_q <= fill_base + 4'd1;
            end
        end
    end

    // ==================================================================
    // element store
    // ==================================================================

    always_ff @(posedge clk) begin
        if (word.strobe) begin
            elems_q <= {word.value, elems_q[`MDC_NUM_ELEM-1:1]};
            if (word.first) begin
                mode_q <= word.mode;
            end
        end
    end

    // held until the next matrix begins
    assign matrix = '{
        elems: elems_q,
        mode:  mode_q
    };

endmodule

/* source/mdc_det_engine.sv */
// determinant engine
`timescale 1ns/1ps
`include "mdc_defines.svh"

module mdc_det_engine (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  mdc_pkg::matrix_t   matrix,
    output logic               out_valid,
    output mdc_pkg::out_word_t out_data
);
    import mdc_pkg::*;

    // ==================================================================
    // declarations
    // ==================================================================

    // sequencer
    logic       busy_q;
    logic       is_det3_q;
    logic [3:0] step_q;
    logic       last_step;
    // step split into result group and position in group
    logic [1:0] grp;
    logic [1:0] pos;
    // 3x3 submatrix origin
    logic [1:0] sub_row;
    logic [1:0] sub_col;
    // minor unit selection
    logic [1:0] top_row;
    logic [1:0] col_l;
    logic [1:0] col_r;
    elem_t      e_tl;
    elem_t      e_tr;
    elem_t      e_bl;
    elem_t      e_br;
    logic signed [2*`MDC_ELEM_W-1:0] prod_a;
    logic signed [2*`MDC_ELEM_W-1:0] prod_b;
    det2_t      minor;
    // cofactor path
    elem_t      pivot;
    logic signed [`MDC_ACC_W-1:0] term;
    logic signed [`MDC_ACC_W-1:0] acc_base;
    logic signed [`MDC_ACC_W-1:0] acc_sum;
    logic signed [`MDC_ACC_W-1:0] acc_q;
    out_word_t  res_q;

    function automatic logic [3:0] elem_idx(input logic [1:0] row, input logic [1:0] col);
        return 4'(row * `MDC_DIM + col);
    endfunction

    // 2x2 mode takes one step per slot, 3x3 mode three per slot
    assign grp     = 2'(step_q / 4'd3);
    assign pos     = 2'(step_q % 4'd3);
    assign sub_row = {1'b0, grp[1]};
    assign sub_col = {1'b0, grp[0]};

    assign last_step = busy_q && (step_q == (is_det3_q ? 4'(3 * `MDC_NUM_DET3 - 1)
                                                       : 4'(`MDC_NUM_DET2 - 1)));

    // ==================================================================
    // sequencer
    // ==================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            is_det3_q <= 1'b0;
            step_q    <= 4'd0;
            out_valid <= 1'b0;
        end else begin
            // done pulse one cycle after the final write
            out_valid <= last_step;
            if (start) begin
                busy_q    <= 1'b1;
                step_q    <= 4'd0;
                is_det3_q <= matrix.mode[`MDC_MODE_DET3_BIT];
            end else if (busy_q) begin
                if (last_step) begin
                    busy_q <= 1'b0;
                end else begin
                    step_q <= step_q + 4'd1;
                end
            end
        end
    end

    // ==================================================================
    // element selection and shared minor unit
    // ==================================================================

    always_comb begin
        // 2x2 mode walks the submatrices row-major
        top_row = grp;
        col_l   = pos;
        col_r   = pos + 2'd1;
        pivot   = '0;
        if (is_det3_q) begin
            // first-row expansion, minor from the two rows below
            top_row = sub_row + 2'd1;
            pivot   = matrix.elems[elem_idx(sub_row, sub_col + pos)];
            case (pos)
                2'd0: begin
                    col_l = sub_col + 2'd1;
                    col_r = sub_col + 2'd2;
                end
                2'd1: begin
                    col_l = sub_col;
                    col_r = sub_col + 2'd2;
                end
                default: begin
                    col_l = sub_col;
                    col_r = sub_col + 2'd1;
                end
            endcase
        end
    end

    assign e_tl = matrix.elems[elem_idx(top_row, col_l)];
    assign e_tr = matrix.elems[elem_idx(top_row, col_r)];
    assign e_bl = matrix.elems[elem_idx(top_row + 2'd1, col_l)];
    assign e_br = matrix.elems[elem_idx(top_row + 2'd1, col_r)];

    // | tl tr |
    // | bl br |
    assign prod_a = e_tl * e_br;
    assign prod_b = e_tr * e_bl;
    assign minor  = prod_a - prod_b;

    // ==================================================================
    // cofactor accumulation
    // ==================================================================

    assign term = pivot * minor;

    // signs run + - + across the first row
    always_comb begin
        acc_base = (pos == 2'd0) ? '0 : acc_q;
        if (pos == 2'd1) begin
            acc_sum = acc_base - term;
        end else begin
            acc_sum = acc_base + term;
        end
    end

    always_ff @(posedge clk) begin
        if (busy_q && is_det3_q) begin
            acc_q <= acc_sum;
        end
    end

    // ==================================================================
    // result register and output
    // ==================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_q <= '0;
        end else if (start) begin
            res_q <= '0;
        end else if (busy_q) begin
            if (!is_det3_q) begin
                // slot 8 holds the top left submatrix
                res_q.det2_view[4'(`MDC_NUM_DET2 - 1) - step_q] <= minor;
            end else if (pos == 2'd2) begin
                // sign extend into the wide slot
                res_q.det3_view.slot[2'd3 - grp] <= {
                    {(`MDC_DET3_W - `MDC_ACC_W){acc_sum[`MDC_ACC_W-1]}}, acc_sum
                };
            end
        end
    end

    // word reads zero outside the done pulse
    assign out_data = out_valid ? res_q : '0;

endmodule

/* source/mdc_top.sv */
// determinant calculator top
`timescale 1ns/1ps
`include "mdc_defines.svh"

module mdc_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  logic [`MDC_CODE_W-1:0]      in_data,
    input  logic [`MDC_MODE_CODE_W-1:0] in_mode,
    output logic                        out_valid,
    output mdc_pkg::out_word_t          out_data
);
    import mdc_pkg::*;

    // ==================================================================
    // internal links
    // ==================================================================

    // decoder to buffer, one word per cycle
    dec_word_t dec_word;
    // buffer to engine, full matrix and its start pulse
    matrix_t   matrix;
    logic      start;

    // corrects and registers each code word
    mdc_input_decoder u_decoder (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_mode  (in_mode),
        .word     (dec_word)
    );

    // collects sixteen elements
    mdc_matrix_buffer u_buffer (
        .clk    (clk),
        .rst_n  (rst_n),
        .word   (dec_word),
        .matrix (matrix),
        .start  (start)
    );

    // sequences minors into the output word
    mdc_det_engine u_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .matrix    (matrix),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

/* sim/mdc_assert.sv */
// output protocol assertions
`timescale 1ns/1ps

module mdc_assert (
    input logic               clk,
    input logic               rst_n,
    input logic               out_valid,
    input mdc_pkg::out_word_t out_data
);

    // count of failed properties
    int unsigned fail_count = 0;

    // ======================================================================
    // output strobe and data
    // ======================================================================

    // done pulse lasts a single cycle
    pulse_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid
    ) else begin
        fail_count++;
        $error("out_valid stayed high for two cycles");
    end

    // result word is gated to zero outside the pulse
    data_zero_idle: assert property (
        @(posedge clk) !out_valid |-> (out_data == '0)
    ) else begin
        fail_count++;
        $error("out_data not zero while out_valid is low");
    end

    // nothing leaves the engine in reset
    quiet_in_reset: assert property (
        @(posedge clk) !rst_n |-> !out_valid
    ) else begin
        fail_count++;
        $error("out_valid high during reset");
    end

endmodule

bind mdc_top mdc_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .out_data  (out_data)
);

/* sim/mdc_tb.sv */
// determinant calculator testbench
`timescale 1ns/1ps
`include "mdc_defines.svh"

module mdc_tb;
    import mdc_pkg::*;

    localparam int NUM_MATRICES = 14;
    // reset, idle stretch and slack
    localparam int MARGIN_CYCLES = 100;
    // mode bit 1 sits at code position 7, index 2 of the mode code
    localparam int MODE_SEL_IDX = 2;

    logic                        clk;
    logic                        rst_n;
    logic                        in_valid;
    logic [`MDC_CODE_W-1:0]      in_data;
    logic [`MDC_MODE_CODE_W-1:0] in_mode;
    logic                        out_valid;
    out_word_t                   out_data;

    logic [31:0] rng_state;
    // intended matrix, row-major
    elem_t       mat [`MDC_NUM_ELEM];

    mdc_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_mode   (in_mode),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ======================================================================
    // helpers
    // ======================================================================

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // data in the non power of two positions, position 1 is the msb
    function automatic logic [`MDC_CODE_W-1:0] hamming_encode(
        input logic [`MDC_ELEM_W-1:0] data
    );
        logic [`MDC_CODE_W-1:0] code;
        logic [3:0]             syn;
        int                     k;
        code = '0;
        k    = `MDC_ELEM_W - 1;
        for (int p = 1; p <= `MDC_CODE_W; p++) begin
            if (p != 1 && p != 2 && p != 4 && p != 8) begin
                code[`MDC_CODE_W - p] = data[k];
                k = k - 1;
            end
        end
        syn = '0;
        for (int p = 1; p <= `MDC_CODE_W; p++) begin
            if (code[`MDC_CODE_W - p]) begin
                syn = syn ^ 4'(p);
            end
        end
        // parity bits cancel the data syndrome
        code[`MDC_CODE_W - 1] = syn[0];
        code[`MDC_CODE_W - 2] = syn[1];
        code[`MDC_CODE_W - 4] = syn[2];
        code[`MDC_CODE_W - 8] = syn[3];
        return code;
    endfunction

    function automatic longint elem_at(input int r, input int c);
        return longint'(mat[r * `MDC_DIM + c]);
    endfunction

    function automatic det2_t det2_model(input int r, input int c);
        return det2_t'(elem_at(r, c) * elem_at(r + 1, c + 1)
                       - elem_at(r, c + 1) * elem_at(r + 1, c));
    endfunction

    // cofactor expansion along the top row of the 3x3 block
    function automatic det3_t det3_model(input int r, input int c);
        longint d;
        d = elem_at(r, c) * (elem_at(r + 1, c + 1) * elem_at(r + 2, c + 2)
                             - elem_at(r + 1, c + 2) * elem_at(r + 2, c + 1))
          - elem_at(r, c + 1) * (elem_at(r + 1, c) * elem_at(r + 2, c + 2)
                                 - elem_at(r + 1, c + 2) * elem_at(r + 2, c))
          + elem_at(r, c + 2) * (elem_at(r + 1, c) * elem_at(r + 2, c + 1)
                                 - elem_at(r + 1, c + 1) * elem_at(r + 2, c));
        return det3_t'(d);
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    // ======================================================================
    // compare tasks
    // ======================================================================

    task automatic check_det2(input string name, input det2_t got, input det2_t exp);
        if (got !== exp) begin
            report_failure($sformatf("error at %0t ns: %s got %0d expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_det3(input string name, input det3_t got, input det3_t exp);
        if (got !== exp) begin
            report_failure($sformatf("error at %0t ns: %s got %0d expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_pad(input string name, input logic [DET3_PAD_W-1:0] got);
        if (got !== '0) begin
            report_failure($sformatf("error at %0t ns: %s got %b expected %b",
                                     $time, name, got, {DET3_PAD_W{1'b0}}));
        end
    endtask

    task automatic check_word(input string name, input out_word_t got, input out_word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("error at %0t ns: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("error at %0t ns: %s got %b expected %b",
                                     $time, name, got, exp));
        end
    endtask

    // ======================================================================
    // stimulus and checking
    // ======================================================================

    // sixteen code words, mode on the first, optional single bit errors
    // mode_flip is the mode code bit to invert, negative for a clean code
    task automatic send_matrix(input logic det3, input logic data_err, input int mode_flip);
        logic [31:0]                 r;
        logic [`MDC_MODE_W-1:0]      mode;
        logic [`MDC_CODE_W-1:0]      code;
        logic [`MDC_MODE_CODE_W-1:0] mode_code;
        int                          idx;
        r    = next_rand();
        mode = r[`MDC_MODE_W-1:0];
        mode[`MDC_MODE_DET3_BIT] = det3;
        // shortened mode code is the top of a zero filled data code
        code      = hamming_encode({mode, {(`MDC_ELEM_W - `MDC_MODE_W){1'b0}}});
        mode_code = code[`MDC_CODE_W-1 -: `MDC_MODE_CODE_W];
        if (mode_flip >= 0) begin
            mode_code[mode_flip] = ~mode_code[mode_flip];
        end
        for (int i = 0; i < `MDC_NUM_ELEM; i++) begin
            r      = next_rand();
            mat[i] = r[`MDC_ELEM_W-1:0];
            code   = hamming_encode(mat[i]);
            if (data_err) begin
                idx = int'(r[31:16] % `MDC_CODE_W);
                code[idx] = ~code[idx];
            end
            @(posedge clk);
            in_valid <= 1'b1;
            in_data  <= code;
            // mode lines carry noise after the first word
            in_mode  <= (i == 0) ? mode_code : r[`MDC_MODE_CODE_W+11:12];
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // output must read zero until the pulse
    task automatic wait_result();
        do begin
            @(negedge clk);
            if (!out_valid) begin
                check_word("out_data", out_data, '0);
            end
        end while (!out_valid);
    endtask

    task automatic check_results(input logic det3);
        int g;
        if (!det3) begin
            for (int s = 0; s < `MDC_NUM_DET2; s++) begin
                g = `MDC_NUM_DET2 - 1 - s;
                check_det2($sformatf("out_data.det2_view[%0d]", s),
                           out_data.det2_view[s], det2_model(g / 3, g % 3));
            end
        end else begin
            for (int s = 0; s < `MDC_NUM_DET3; s++) begin
                g = `MDC_NUM_DET3 - 1 - s;
                check_det3($sformatf("out_data.det3_view.slot[%0d]", s),
                           out_data.det3_view.slot[s], det3_model(g / 2, g % 2));
            end
            check_pad("out_data.det3_view.pad", out_data.det3_view.pad);
        end
    endtask

    task automatic run_case(input logic det3, input logic data_err, input int mode_flip);
        send_matrix(det3, data_err, mode_flip);
        wait_result();
        check_results(det3);
    endtask

    // ======================================================================
    // main sequence and watchdog
    // ======================================================================

    initial begin
        logic [31:0] r;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        in_mode   = '0;
        rng_state = 32'd91888;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        // idle stretch after reset
        repeat (10) begin
            @(negedge clk);
            check_flag("out_valid", out_valid, 1'b0);
            check_word("out_data", out_data, '0);
        end
        // clean codes in both modes
        run_case(1'b0, 1'b0, -1);
        run_case(1'b1, 1'b0, -1);
        // corrupted data codes
        run_case(1'b0, 1'b1, -1);
        run_case(1'b1, 1'b1, -1);
        // corrupted mode code, hitting the bit that picks the mode
        run_case(1'b0, 1'b0, MODE_SEL_IDX);
        run_case(1'b1, 1'b0, MODE_SEL_IDX);
        // back to back, random modes and errors
        for (int n = 0; n < NUM_MATRICES - 6; n++) begin
            r = next_rand();
            run_case(r[0], r[1], r[2] ? int'(r[15:8] % `MDC_MODE_CODE_W) : -1);
        end
        if (DUT.u_assert.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        repeat (NUM_MATRICES * 40 + MARGIN_CYCLES) @(posedge clk);
        report_failure("watchdog expired before all matrices were checked");
    end

endmodule

/* mdc.f */
+incdir+include
source/mdc_pkg.sv
source/mdc_input_decoder.sv
source/mdc_matrix_buffer.sv
source/mdc_det_engine.sv
source/mdc_top.sv
sim/mdc_assert.sv
sim/mdc_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the determinant calculator testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module mdc_tb -f mdc.f -o mdc_sim
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/mdc_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
exit 0
